/* logic/rf_pkg.sv */
// Register file widths, types, alert causes and SEC-DED encode and syndrome functions
package rf_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////

  localparam int DATA_W   = 32;
  localparam int ECC_W    = 7;
  localparam int NUM_REGS = 32;
  localparam int ADDR_W   = 5;

  typedef logic [ADDR_W-1:0]       rf_addr_t;
  typedef logic [DATA_W-1:0]       rf_data_t;
  // Data in the low bits, check bits on top
  typedef logic [DATA_W+ECC_W-1:0] rf_word_t;

  // Most recent alert source
  typedef enum logic [1:0] {
    ALERT_NONE,
    ALERT_ECC,
    ALERT_CSR,
    ALERT_LFSR
  } alert_cause_e;

  ////////////////////////////////////////////////////////////
  // SEC-DED code
  ////////////////////////////////////////////////////////////

  // Hamming check bits 0..5
  // Data bits sit on positions 3,5,6,7,9.. skipping powers of two
  function automatic logic [ECC_W-2:0] hamming_chk(rf_data_t data);
    logic [ECC_W-2:0] chk;
    int unsigned      idx;
    chk = '0;
    idx = 0;
    for (int unsigned pos = 3; pos < DATA_W + ECC_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        for (int j = 0; j < ECC_W - 1; j++) begin
          if (pos[j]) begin
            chk[j] = chk[j] ^ data[idx];
          end
        end
        idx++;
      end
    end
    return chk;
  endfunction

  // Overall parity goes in the top bit
  function automatic rf_word_t ecc_encode(rf_data_t data);
    logic [ECC_W-2:0] chk;
    chk = hamming_chk(data);
    return {^{chk, data}, chk, data};
  endfunction

  // Zero only for a valid codeword
  function automatic logic [ECC_W-1:0] ecc_syndrome(rf_word_t word);
    logic [ECC_W-2:0] chk;
    chk = hamming_chk(word[DATA_W-1:0]);
    return {^word, chk ^ word[DATA_W+ECC_W-2:DATA_W]};
  endfunction

endpackage

/* logic/rf_read_if.sv */
// Read port interface between read port, codeword storage and alert unit
`timescale 1ns/1ns

interface rf_read_if;

  // Request from the read port
  rf_pkg::rf_addr_t raddr;
  logic             re;

  // Stored codeword back from the array
  rf_pkg::rf_word_t rword;

  // Syndrome check result
  logic             ecc_err;

  modport reader (
    output raddr,
    output re,
    output ecc_err,
    input  rword
  );

  modport store (
    input  raddr,
    output rword
  );

  modport alert (
    input  ecc_err
  );

endinterface

/* logic/rf_storage.sv */
// Register file codeword storage with ECC encoding, x0 dummy gating and per-port lookup
`timescale 1ns/1ns

module rf_storage #(
  parameter int NUM_READ_PORTS = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Write port
  input  logic             we_i,
  input  logic             dummy_wr_i,
  input  rf_pkg::rf_addr_t waddr_i,
  input  rf_pkg::rf_data_t wdata_i,

  // Codeword lookup, one per read port
  rf_read_if.store         rd_ports [NUM_READ_PORTS]
);

  // Codeword of all-zero data
  localparam rf_pkg::rf_word_t ZERO_WORD = rf_pkg::ecc_encode(rf_pkg::rf_data_t'(0));

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  rf_pkg::rf_word_t mem_q [rf_pkg::NUM_REGS];

  // Encoded write data
  rf_pkg::rf_word_t wr_word;

  // Write targets x0
  logic             wr_x0;

  // Final write strobe after x0 gating
  logic             wr_en;

  assign wr_word = rf_pkg::ecc_encode(wdata_i);

  assign wr_x0 = (waddr_i == '0);

  // x0 only takes writes from dummy instructions
  assign wr_en = we_i && (!wr_x0 || dummy_wr_i);

  ////////////////////////////////////////////////////////////
  // Codeword array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // Every entry back to a valid zero codeword
      for (int r = 0; r < rf_pkg::NUM_REGS; r++) begin
        mem_q[r] <= ZERO_WORD;
      end
    end else if (wr_en) begin
      mem_q[waddr_i] <= wr_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read lookup
  ////////////////////////////////////////////////////////////

  // No bypass
  // same-cycle write is seen only after the edge
  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_lookup
    assign rd_ports[p].rword = mem_q[rd_ports[p].raddr];
  end

endmodule

/* logic/rf_read_port.sv */
// Register file read port with syndrome check, check-bit strip and x0 read rule
`timescale 1ns/1ns

module rf_read_port (
  input  logic             re_i,
  input  logic             dummy_rd_i,
  input  rf_pkg::rf_addr_t raddr_i,
  output rf_pkg::rf_data_t rdata_o,

  // Link to storage and alert unit
  rf_read_if.reader        rd_if
);

  // Syndrome of the returned codeword
  logic [rf_pkg::ECC_W-1:0] syndrome;

  // Data part of the codeword
  rf_pkg::rf_data_t         word_data;

  // Address decode for x0
  logic                     is_x0;
  logic                     mask_x0;

  ////////////////////////////////////////////////////////////
  // Request
  ////////////////////////////////////////////////////////////

  assign rd_if.raddr = raddr_i;
  assign rd_if.re    = re_i;

  ////////////////////////////////////////////////////////////
  // ECC check
  ////////////////////////////////////////////////////////////

  assign syndrome = rf_pkg::ecc_syndrome(rd_if.rword);

  // Flag only on an enabled read
  assign rd_if.ecc_err = rd_if.re && (syndrome != '0);

  ////////////////////////////////////////////////////////////
  // Data out
  ////////////////////////////////////////////////////////////

  // Check bits dropped
  assign word_data = rd_if.rword[rf_pkg::DATA_W-1:0];

  assign is_x0 = (raddr_i == '0);

  // x0 reads as zero unless this is a dummy read
  assign mask_x0 = is_x0 && !dummy_rd_i;

  assign rdata_o = mask_x0 ? '0 : word_data;

endmodule

/* logic/rf_alert.sv */
// Alert unit registering major and minor alerts and the last alert cause
`timescale 1ns/1ns

module rf_alert #(
  parameter int NUM_READ_PORTS = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  // External triggers
  input  logic     csr_err_i,
  input  logic     lfsr_lockup_i,

  // ECC errors from all read ports
  rf_read_if.alert rd_ports [NUM_READ_PORTS],

  output logic     alert_major_o,
  output logic     alert_minor_o
);

  logic [NUM_READ_PORTS-1:0] ecc_err_vec;
  logic                      ecc_any;

  logic                      major_q;
  logic                      minor_q;

  // Debug only
  rf_pkg::alert_cause_e      cause_q;
  rf_pkg::alert_cause_e      cause_d;

  // Gather per-port errors
  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_ecc
    assign ecc_err_vec[p] = rd_ports[p].ecc_err;
  end

  assign ecc_any = |ecc_err_vec;

  // Keep old cause when nothing fires
  // ECC wins over CSR, CSR over lockup
  always_comb begin
    cause_d = cause_q;
    if (ecc_any) begin
      cause_d = rf_pkg::ALERT_ECC;
    end else if (csr_err_i) begin
      cause_d = rf_pkg::ALERT_CSR;
    end else if (lfsr_lockup_i) begin
      cause_d = rf_pkg::ALERT_LFSR;
    end
  end

  ////////////////////////////////////////////////////////////
  // Alert registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      major_q <= 1'b0;
      minor_q <= 1'b0;
      cause_q <= rf_pkg::ALERT_NONE;
    end else begin
      major_q <= csr_err_i || ecc_any;
      minor_q <= lfsr_lockup_i;
      cause_q <= cause_d;
    end
  end

  assign alert_major_o = major_q;
  assign alert_minor_o = minor_q;

endmodule

/* logic/rf_secure_top.sv */
// Hardened register file top level with storage, read ports and alert unit
`timescale 1ns/1ns

module rf_secure_top #(
  parameter int NUM_READ_PORTS = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,

  // Write port
  input  logic                                    we_i,
  input  rf_pkg::rf_addr_t                        waddr_i,
  input  rf_pkg::rf_data_t                        wdata_i,
  input  logic                                    dummy_wr_i,

  // Read ports, indexed by port
  input  logic             [NUM_READ_PORTS-1:0]   re_i,
  input  rf_pkg::rf_addr_t [NUM_READ_PORTS-1:0]   raddr_i,
  input  logic             [NUM_READ_PORTS-1:0]   dummy_rd_i,
  output rf_pkg::rf_data_t [NUM_READ_PORTS-1:0]   rdata_o,

  // Alert triggers from outside
  input  logic                                    csr_err_i,
  input  logic                                    lfsr_lockup_i,

  output logic                                    alert_major_o,
  output logic                                    alert_minor_o
);

  // One link per read port
  rf_read_if rd_if [NUM_READ_PORTS] ();

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  rf_storage #(
    .NUM_READ_PORTS ( NUM_READ_PORTS )
  ) rf_storage_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .we_i           ( we_i           ),
    .dummy_wr_i     ( dummy_wr_i     ),
    .waddr_i        ( waddr_i        ),
    .wdata_i        ( wdata_i        ),
    .rd_ports       ( rd_if          )
  );

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_READ_PORTS; g++) begin : g_read_port
    rf_read_port read_port_i (
      .re_i       ( re_i[g]       ),
      .dummy_rd_i ( dummy_rd_i[g] ),
      .raddr_i    ( raddr_i[g]    ),
      .rdata_o    ( rdata_o[g]    ),
      .rd_if      ( rd_if[g]      )
    );
  end

  ////////////////////////////////////////////////////////////
  // Alerts
  ////////////////////////////////////////////////////////////

  rf_alert #(
    .NUM_READ_PORTS ( NUM_READ_PORTS )
  ) rf_alert_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .csr_err_i      ( csr_err_i      ),
    .lfsr_lockup_i  ( lfsr_lockup_i  ),
    .rd_ports       ( rd_if          ),
    .alert_major_o  ( alert_major_o  ),
    .alert_minor_o  ( alert_minor_o  )
  );

endmodule

/* testbench/tb_clkgen.sv */
// Testbench clock and synchronous active-low reset generator
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset over the first rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* testbench/rf_chk.sv */
// Concurrent assertions on the register file alert outputs and last alert cause, bound to the top level
`timescale 1ns/1ns

module rf_chk (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 csr_err_i,
  input logic                 lfsr_lockup_i,
  input logic                 ecc_any_i,
  input rf_pkg::alert_cause_e cause_i,
  input logic                 alert_major_i,
  input logic                 alert_minor_i
);

  // Failed assertions so far, watched by the testbench
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // Reset
  ////////////////////////////////////////////////////////////

  // Alerts cleared one cycle into reset
  assert property (@(posedge clk_i) !rst_n_i |=> !alert_major_i && !alert_minor_i)
    else begin
      $error("alert high in the cycle after reset");
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////
  // Alert sources
  ////////////////////////////////////////////////////////////

  // Minor alert is lockup delayed by one cycle
  assert property (@(posedge clk_i) rst_n_i |=> alert_minor_i == $past(lfsr_lockup_i))
    else begin
      $error("alert_minor_o does not follow lfsr_lockup_i");
      fail_cnt++;
    end

  // Major alert needs a CSR error or an ECC error one cycle back
  assert property (@(posedge clk_i)
    rst_n_i |=> !alert_major_i || $past(csr_err_i) || $past(ecc_any_i))
    else begin
      $error("alert_major_o high without a trigger");
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////
  // Last cause
  ////////////////////////////////////////////////////////////

  // A lone CSR error is recorded as the cause
  assert property (@(posedge clk_i)
    rst_n_i && csr_err_i && !lfsr_lockup_i && !ecc_any_i |=> cause_i == rf_pkg::ALERT_CSR)
    else begin
      $error("last alert cause is not CSR after a CSR error");
      fail_cnt++;
    end

  // A lone lockup is recorded as the cause
  assert property (@(posedge clk_i)
    rst_n_i && lfsr_lockup_i && !csr_err_i && !ecc_any_i |=> cause_i == rf_pkg::ALERT_LFSR)
    else begin
      $error("last alert cause is not LFSR after a lockup");
      fail_cnt++;
    end

endmodule

/* testbench/tb_rf.sv */
// Directed register file tests with reference model, LFSR data, compare tasks and watchdog
`timescale 1ns/1ns

module tb_rf;

  localparam int NP         = 3;
  localparam int PERIOD_NS  = 10;
  localparam int NUM_WRITES = 40;

  // Cycle budget per test, summed for the watchdog
  localparam int CYC_RESET = 4 + 2;
  localparam int CYC_CLEAR = rf_pkg::NUM_REGS;
  localparam int CYC_WRRD  = 2 * NUM_WRITES + 1;
  localparam int CYC_X0    = 4;
  localparam int CYC_RDW   = 2;
  localparam int CYC_ALERT = 6;
  localparam int WDOG_NS   =
    (CYC_RESET + CYC_CLEAR + CYC_WRRD + CYC_X0 + CYC_RDW + CYC_ALERT + 20) * PERIOD_NS;

  logic                      clk;
  logic                      rst_n;
  logic                      we;
  logic                      dummy_wr;
  rf_pkg::rf_addr_t          waddr;
  rf_pkg::rf_data_t          wdata;
  logic             [NP-1:0] re;
  logic             [NP-1:0] dummy_rd;
  rf_pkg::rf_addr_t [NP-1:0] raddr;
  rf_pkg::rf_data_t [NP-1:0] rdata;
  logic                      csr_err;
  logic                      lfsr_lockup;
  logic                      alert_major;
  logic                      alert_minor;

  // Expected register contents
  rf_pkg::rf_data_t model [rf_pkg::NUM_REGS];
  logic [31:0]      lfsr_q;

  tb_clkgen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(4)) clkgen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  rf_secure_top #(.NUM_READ_PORTS(NP)) uut (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .we_i          ( we          ),
    .waddr_i       ( waddr       ),
    .wdata_i       ( wdata       ),
    .dummy_wr_i    ( dummy_wr    ),
    .re_i          ( re          ),
    .raddr_i       ( raddr       ),
    .dummy_rd_i    ( dummy_rd    ),
    .rdata_o       ( rdata       ),
    .csr_err_i     ( csr_err     ),
    .lfsr_lockup_i ( lfsr_lockup ),
    .alert_major_o ( alert_major ),
    .alert_minor_o ( alert_minor )
  );

  bind rf_secure_top rf_chk chk_i (
    .clk_i         ( clk_i              ),
    .rst_n_i       ( rst_n_i            ),
    .csr_err_i     ( csr_err_i          ),
    .lfsr_lockup_i ( lfsr_lockup_i      ),
    .ecc_any_i     ( rf_alert_i.ecc_any ),
    .cause_i       ( rf_alert_i.cause_q ),
    .alert_major_i ( alert_major_o      ),
    .alert_minor_i ( alert_minor_o      )
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////

  task automatic abort_run(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(string name, rf_pkg::rf_data_t exp, rf_pkg::rf_data_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_alert(string name, logic exp, logic act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // Address in 1..31
  task automatic draw_addr(output rf_pkg::rf_addr_t addr);
    logic [31:0] r;
    draw_bits(8, r);
    addr = rf_pkg::rf_addr_t'(r % 32'd31 + 32'd1);
  endtask

  task automatic drive_write(logic w, rf_pkg::rf_addr_t a, rf_pkg::rf_data_t d, logic dmy);
    we       = w;
    waddr    = a;
    wdata    = d;
    dummy_wr = dmy;
  endtask

  // x0 keeps only dummy writes
  task automatic model_write(rf_pkg::rf_addr_t a, rf_pkg::rf_data_t d, logic dmy);
    if (a != '0 || dmy) begin
      model[a] = d;
    end
  endtask

  // x0 reads zero unless dummy
  function automatic rf_pkg::rf_data_t exp_read(rf_pkg::rf_addr_t a, logic dmy);
    if (a == '0 && !dmy) begin
      return '0;
    end
    return model[a];
  endfunction

  task automatic check_ports(string name);
    for (int p = 0; p < NP; p++) begin
      check_data($sformatf("%s port %0d", name, p), exp_read(raddr[p], dummy_rd[p]), rdata[p]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    for (int a = 0; a < rf_pkg::NUM_REGS; a++) begin
      @(negedge clk);
      re       = '1;
      dummy_rd = '1;
      raddr    = {NP{rf_pkg::rf_addr_t'(a)}};
      #1;
      for (int p = 0; p < NP; p++) begin
        check_data($sformatf("reset port %0d", p), '0, rdata[p]);
      end
      check_alert("reset major", 1'b0, alert_major);
      check_alert("reset minor", 1'b0, alert_minor);
    end
  endtask

  task automatic test_write_read();
    rf_pkg::rf_addr_t a;
    rf_pkg::rf_addr_t ra;
    logic [31:0]      d;
    for (int i = 0; i < NUM_WRITES; i++) begin
      draw_addr(a);
      draw_bits(32, d);
      @(negedge clk);
      drive_write(1'b1, a, d, 1'b0);
      re = '0;
      @(negedge clk);
      model_write(a, d, 1'b0);
      drive_write(1'b0, a, '0, 1'b0);
      re       = '1;
      dummy_rd = '0;
      raddr[0] = a;
      // Other ports look around the file
      for (int p = 1; p < NP; p++) begin
        draw_addr(ra);
        raddr[p] = ra;
      end
      #1;
      check_ports("write_read");
      check_alert("write_read major", 1'b0, alert_major);
    end
    @(negedge clk);
    #1;
    check_alert("write_read major", 1'b0, alert_major);
  endtask

  task automatic test_x0_dummy();
    logic [31:0] d;
    logic [31:0] e;
    draw_bits(32, d);
    draw_bits(32, e);
    @(negedge clk);
    drive_write(1'b1, '0, d, 1'b1);
    @(negedge clk);
    model_write('0, d, 1'b1);
    drive_write(1'b0, '0, '0, 1'b0);
    raddr       = '0;
    re          = '1;
    dummy_rd    = '1;
    // Port 1 does a plain x0 read
    dummy_rd[1] = 1'b0;
    #1;
    check_ports("x0 dummy write");
    @(negedge clk);
    drive_write(1'b1, '0, e, 1'b0);
    @(negedge clk);
    model_write('0, e, 1'b0);
    drive_write(1'b0, '0, '0, 1'b0);
    #1;
    check_ports("x0 plain write");
    check_data("x0 dummy read", d, rdata[0]);
  endtask

  task automatic test_read_during_write();
    rf_pkg::rf_addr_t a;
    logic [31:0]      d;
    draw_addr(a);
    draw_bits(32, d);
    if (d == model[a]) begin
      d = ~d;
    end
    @(negedge clk);
    drive_write(1'b1, a, d, 1'b0);
    raddr    = {NP{a}};
    re       = '1;
    dummy_rd = '0;
    // Model still holds the old value here
    #1;
    check_ports("read during write");
    @(negedge clk);
    model_write(a, d, 1'b0);
    drive_write(1'b0, a, '0, 1'b0);
    #1;
    check_ports("read after write");
  endtask

  // One-cycle trigger, alert expected exactly one cycle later
  task automatic pulse_trigger(string name, logic is_csr);
    @(negedge clk);
    csr_err     = is_csr;
    lfsr_lockup = !is_csr;
    #1;
    check_alert({name, " major early"}, 1'b0, alert_major);
    check_alert({name, " minor early"}, 1'b0, alert_minor);
    @(negedge clk);
    csr_err     = 1'b0;
    lfsr_lockup = 1'b0;
    #1;
    check_alert({name, " major"}, is_csr, alert_major);
    check_alert({name, " minor"}, !is_csr, alert_minor);
    @(negedge clk);
    #1;
    check_alert({name, " major late"}, 1'b0, alert_major);
    check_alert({name, " minor late"}, 1'b0, alert_minor);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    drive_write(1'b0, '0, '0, 1'b0);
    re          = '0;
    dummy_rd    = '0;
    raddr       = '0;
    csr_err     = 1'b0;
    lfsr_lockup = 1'b0;
    lfsr_q      = 32'hf9c68780;
    // Reset state of the file
    for (int r = 0; r < rf_pkg::NUM_REGS; r++) begin
      model[r] = '0;
    end
    @(posedge rst_n);
    test_reset();
    test_write_read();
    test_x0_dummy();
    test_read_during_write();
    pulse_trigger("csr_err", 1'b1);
    pulse_trigger("lfsr_lockup", 1'b0);
    @(negedge clk);
    $display("all tests passed");
    $finish;
  end

  // Bound checker counts its assertion failures
  initial begin
    wait (uut.chk_i.fail_cnt != 0);
    abort_run("an assertion in the bound checker failed");
  end

  initial begin
    #(WDOG_NS);
    abort_run("watchdog expired before the tests completed");
  end

endmodule

/* build.f */
logic/rf_pkg.sv
logic/rf_read_if.sv
logic/rf_storage.sv
logic/rf_read_port.sv
logic/rf_alert.sv
logic/rf_secure_top.sv
testbench/tb_clkgen.sv
testbench/rf_chk.sv
testbench/tb_rf.sv

/* Makefile */
# Verilator build and run of the register file testbench
SIM  := obj_dir/Vtb_rf
SRCS := $(shell grep -v '^+' build.f)

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_rf -f build.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q '^all tests passed$$' sim.log

clean:
	rm -rf obj_dir sim.log
